// File: dv/fetch_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_asserts (
   input logic                                 clk,
   input logic                                 rst_n_i,
   input logic                                 group_valid_i,
   input logic [fetch_pkg::CREDIT_W-1:0]       credit_i,   // Free buffer entries
   input logic [fetch_pkg::FETCH_W-1:0]        mask_i,     // Slot mask of the group
   input fetch_pkg::resolve_t                  resolve_i
);

   import fetch_pkg::*;

   logic flush;
   int   fail_cnt = 0;                                       // Failed properties so far

   assign flush = resolve_i.valid && resolve_i.mispredict;   // Redirect cycle

   // ========================================
   // Credit rules
   // ========================================
   a_send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n_i)
      group_valid_i |-> (credit_i != '0))
      else begin
         $error("group sent with zero credits");
         fail_cnt++;
      end

   a_credit_capped: assert property (@(posedge clk) disable iff (!rst_n_i)
      credit_i <= CREDIT_W'(BUF_CREDITS))
      else begin
         $error("credit count above buffer depth");
         fail_cnt++;
      end

   // ========================================
   // Mask and flush rules
   // ========================================

   // Ones from slot 0 up, no holes
   a_mask_contiguous: assert property (@(posedge clk) disable iff (!rst_n_i)
      mask_i[0] && ((mask_i & (mask_i + FETCH_W'(1))) == '0))
      else begin
         $error("slot mask not contiguous from slot 0");
         fail_cnt++;
      end

   a_no_send_on_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
      flush |-> !group_valid_i)
      else begin
         $error("group sent in a mispredict cycle");
         fail_cnt++;
      end

endmodule

`default_nettype wire

// File: dv/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

   import fetch_pkg::*;
   import bpred_pkg::*;

   localparam int          MEM_WORDS      = 256;
   localparam int          RESET_CYCLES   = 10;
   localparam int          PHASE_CYCLES   = 300;
   localparam int          TIMEOUT_CYCLES = 3000;   // Six phases plus reset, with margin
   localparam logic [31:0] SEED           = 32'h825f80f8;

   logic                            clk;
   logic                            rst_n_i;
   logic [XLEN-1:0]                 fetch_addr_o;
   logic [FETCH_W-1:0][XLEN-1:0]    instr_i;
   resolve_t                        resolve_i;
   fetch_group_t                    group_o;
   logic                            group_valid_o;
   logic                            credit_return_i;

   // Memory contents plus what the generator put in each word
   logic [XLEN-1:0] imem     [MEM_WORDS];
   opcode_e         kind_mem [MEM_WORDS];
   logic [XLEN-1:0] off_mem  [MEM_WORDS];   // Byte offset of branch or JAL

   // Reference state
   logic [XLEN-1:0] m_pc;
   ctr_t            m_ctr [BHT_ENTRIES];
   int              m_credits;
   int              occ;                    // Groups sitting in the buffer model

   int    value_errs;
   int    proto_errs;
   int    assert_errs;
   int    cycle_cnt;
   int    phase;
   int    pcyc;                             // Cycle within the phase
   string phase_name [6] = '{"basic", "train_taken", "train_not_taken",
                             "backpressure", "mispredict", "mixed"};

   fetch_unit uut (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .fetch_addr_o    (fetch_addr_o),
      .instr_i         (instr_i),
      .resolve_i       (resolve_i),
      .group_o         (group_o),
      .group_valid_o   (group_valid_o),
      .credit_return_i (credit_return_i)
   );

   bind fetch_unit fetch_asserts u_asserts (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .group_valid_i (group_valid_o),
      .credit_i      (credit_q),
      .mask_i        (slot_mask),
      .resolve_i     (resolve_i)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                  // 8 ns period
   end

   // Combinational instruction memory, word index wraps
   always_comb begin
      for (int i = 0; i < FETCH_W; i++) begin
         instr_i[i] = imem[fetch_addr_o[9:2] + 8'(i)];
      end
   end

   // ========================================
   // Stimulus helpers
   // ========================================
   task automatic fill_imem();
      int          r;
      int          t;
      int          off;
      logic [12:0] bimm;
      logic [20:0] jimm;
      for (int w = 0; w < MEM_WORDS; w++) begin
         r = int'($urandom_range(0, 99));
         t = w + int'($urandom_range(1, 8));
         if ($urandom_range(0, 1) == 1) t = w - (t - w);         // Backward
         if (t < 0 || t >= MEM_WORDS) t = w - (t - w);          // Mirror back inside
         off  = (t - w) * 4;
         bimm = 13'(off);
         jimm = 21'(off);
         if (r < 60) begin
            kind_mem[w] = OPC_OTHER;
            off_mem[w]  = '0;
            imem[w]     = {25'($urandom), 7'h13};               // ALU immediate op
         end else if (r < 80) begin
            kind_mem[w] = OPC_BRANCH;
            off_mem[w]  = XLEN'(off);
            imem[w]     = {bimm[12], bimm[10:5], 5'($urandom), 5'($urandom), 3'b000,
                           bimm[4:1], bimm[11], 7'h63};
         end else if (r < 92) begin
            kind_mem[w] = OPC_JAL;
            off_mem[w]  = XLEN'(off);
            imem[w]     = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'($urandom), 7'h6F};
         end else begin
            kind_mem[w] = OPC_JALR;                             // Falls through at fetch
            off_mem[w]  = '0;
            imem[w]     = {12'($urandom), 5'($urandom), 3'b000, 5'($urandom), 7'h67};
         end
      end
   endtask

   // One cycle of buffer drain and resolve traffic, per phase mix
   task automatic drive_cycle();
      int         drain_pct;
      int         br_pct;
      int         mis_pct;
      int         tk_pct;
      int         slot;
      logic [7:0] w;
      drain_pct = 70;
      br_pct    = 0;
      mis_pct   = 0;
      tk_pct    = 50;
      case (phase)
         1: begin
            br_pct = 40;
            tk_pct = 90;
         end
         2: begin
            br_pct = 40;
            tk_pct = 10;
         end
         3: drain_pct = (pcyc < 60) ? 0 : 15;                    // Buffer fills first
         4: mis_pct = 15;
         5: begin
            drain_pct = 50;
            br_pct    = 25;
            mis_pct   = 8;
         end
         default: ;
      endcase
      credit_return_i = (occ > 0) && (int'($urandom_range(0, 99)) < drain_pct);
      resolve_i       = '0;
      if (int'($urandom_range(0, 99)) < br_pct) begin
         // Prefer a real branch in the current group
         slot = int'($urandom_range(0, FETCH_W - 1));
         for (int i = FETCH_W - 1; i >= 0; i--) begin
            w = fetch_addr_o[9:2] + 8'(i);
            if (kind_mem[w] == OPC_BRANCH) slot = i;
         end
         resolve_i.valid     = 1'b1;
         resolve_i.is_branch = 1'b1;
         resolve_i.taken     = int'($urandom_range(0, 99)) < tk_pct;
         resolve_i.pc        = fetch_addr_o + XLEN'(4 * slot);
      end else if (int'($urandom_range(0, 99)) < mis_pct) begin
         resolve_i.valid      = 1'b1;
         resolve_i.mispredict = 1'b1;
         resolve_i.is_branch  = 1'($urandom);
         resolve_i.taken      = 1'($urandom);
         resolve_i.pc         = {22'd0, 8'($urandom), 2'b00};
         resolve_i.target     = {22'd0, 8'($urandom), 2'b00};  // In-range redirect
      end
   endtask

   // ========================================
   // Reference model
   // ========================================

   // Expected group from the modeled PC and counters, plus the next PC
   function automatic fetch_group_t ref_group(input logic [XLEN-1:0] base,
                                              output logic [XLEN-1:0] nxt);
      fetch_group_t    g;
      logic [XLEN-1:0] spc;
      logic [7:0]      w;
      logic            hit;
      hit = 1'b0;
      nxt = base + XLEN'(4 * FETCH_W);                          // Fall-through
      for (int i = 0; i < FETCH_W; i++) begin
         spc             = base + XLEN'(4 * i);
         w               = spc[9:2];
         g.slot[i].instr = imem[w];
         g.slot[i].pc    = spc;
         g.slot[i].taken = (kind_mem[w] == OPC_JAL) ||
                           ((kind_mem[w] == OPC_BRANCH) && m_ctr[spc[6:2]][1]);
         g.valid[i]      = !hit;
         if (g.slot[i].taken && !hit) begin
            hit = 1'b1;
            nxt = spc + off_mem[w];
         end
      end
      return g;
   endfunction

   task automatic report_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      $display("error %s.%s: expected %h, actual %h", phase_name[phase], what, exp, act);
      value_errs++;
   endtask

   task automatic advance_model(input logic flush, input logic send,
                                input logic [XLEN-1:0] nxt);
      logic [4:0] idx;
      idx = resolve_i.pc[6:2];
      if (!rst_n_i) begin
         m_pc      = RESET_PC;
         m_credits = BUF_CREDITS;
         occ       = 0;
         for (int e = 0; e < BHT_ENTRIES; e++) m_ctr[e] = 2'b01;
      end else begin
         if (flush) m_pc = resolve_i.target;
         else if (send) m_pc = nxt;
         if (resolve_i.valid && resolve_i.is_branch) begin
            if (resolve_i.taken && m_ctr[idx] != 2'b11) m_ctr[idx] = m_ctr[idx] + 2'b01;
            if (!resolve_i.taken && m_ctr[idx] != 2'b00) m_ctr[idx] = m_ctr[idx] - 2'b01;
         end
         if (group_valid_o) occ++;                              // What the DUT really sent
         if (occ > BUF_CREDITS) begin
            $display("buffer overflow: more groups sent than the buffer can hold");
            proto_errs++;
         end
         if (credit_return_i && m_credits >= BUF_CREDITS) begin
            $display("illegal credit return: credit count is already at buffer depth");
            proto_errs++;
         end
         if (credit_return_i && occ > 0) occ--;
         if (send && !credit_return_i) m_credits--;
         else if (!send && credit_return_i && m_credits < BUF_CREDITS) m_credits++;
      end
   endtask

   // ========================================
   // Comparison, just ahead of each rising edge
   // ========================================
   always @(negedge clk) begin : compare_proc
      fetch_group_t    exp_grp;
      logic [XLEN-1:0] exp_next;
      logic            exp_flush;
      logic            exp_send;
      #2;
      exp_flush = rst_n_i && resolve_i.valid && resolve_i.mispredict;
      exp_send  = rst_n_i && !exp_flush && (m_credits != 0);
      exp_grp   = ref_group(m_pc, exp_next);
      if (group_valid_o !== exp_send) report_value("group_valid", 32'(exp_send),
                                                   32'(group_valid_o));
      if (rst_n_i) begin
         if (fetch_addr_o !== m_pc) report_value("fetch_addr", m_pc, fetch_addr_o);
         if (group_o.valid !== exp_grp.valid) report_value("mask", 32'(exp_grp.valid),
                                                           32'(group_o.valid));
         for (int i = 0; i < FETCH_W; i++) begin
            if (group_o.slot[i].instr !== exp_grp.slot[i].instr)
               report_value($sformatf("slot%0d.instr", i), exp_grp.slot[i].instr,
                            group_o.slot[i].instr);
            if (group_o.slot[i].pc !== exp_grp.slot[i].pc)
               report_value($sformatf("slot%0d.pc", i), exp_grp.slot[i].pc,
                            group_o.slot[i].pc);
            if (group_o.slot[i].taken !== exp_grp.slot[i].taken)
               report_value($sformatf("slot%0d.taken", i), 32'(exp_grp.slot[i].taken),
                            32'(group_o.slot[i].taken));
         end
      end
      advance_model(exp_flush, exp_send, exp_next);
   end

   // Hang guard
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run still going after %0d cycles", cycle_cnt);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // ========================================
   // Main sequence
   // ========================================
   initial begin
      void'($urandom(SEED));
      value_errs      = 0;
      proto_errs      = 0;
      assert_errs     = 0;
      cycle_cnt       = 0;
      phase           = 0;
      pcyc            = 0;
      occ             = 0;
      m_pc            = RESET_PC;
      m_credits       = BUF_CREDITS;
      rst_n_i         = 1'b0;
      credit_return_i = 1'b0;
      resolve_i       = '0;
      fill_imem();
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n_i = 1'b1;
      for (int p = 0; p < 6; p++) begin
         phase = p;
         for (int c = 0; c < PHASE_CYCLES; c++) begin
            pcyc = c;
            drive_cycle();
            @(negedge clk);
         end
      end
      credit_return_i = 1'b0;
      resolve_i       = '0;
      repeat (2) @(negedge clk);
      assert_errs = uut.u_asserts.fail_cnt;
      $display("errors: %0d value, %0d protocol, %0d assertion", value_errs, proto_errs,
               assert_errs);
      if (value_errs == 0 && proto_errs == 0 && assert_errs == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# Build the simulator from the file list
verilator --binary --assert --top-module fetch_tb -f superfetch.f -Mdir obj_dir -o fetch_sim

# Run it, the pass message decides the outcome
sim_out=$(./obj_dir/fetch_sim 2>&1) || true
echo "$sim_out"

if ! grep -q "RESULT: PASS" <<< "$sim_out"; then
   exit 1
fi

// File: src/bpred_pkg.sv
`default_nettype none

package bpred_pkg;

   localparam int BHT_ENTRIES = 32;
   localparam int BHT_IDX_W   = $clog2(BHT_ENTRIES);  // 5

   typedef logic [1:0] ctr_t;                         // 2-bit saturating counter

   localparam ctr_t CTR_MIN = 2'b00;                  // Strongly not taken
   localparam ctr_t CTR_WNT = 2'b01;                  // Weakly not taken, reset value
   localparam ctr_t CTR_MAX = 2'b11;                  // Strongly taken

   // Word-aligned PC bits select the entry
   function automatic logic [BHT_IDX_W-1:0] bht_index(
      input logic [fetch_pkg::XLEN-1:0] pc
   );
      return pc[BHT_IDX_W+1:2];
   endfunction

   // Saturating step toward the resolved outcome
   function automatic ctr_t ctr_next(input ctr_t ctr, input logic taken);
      ctr_t nxt;
      if (taken) begin
         nxt = (ctr == CTR_MAX) ? ctr : ctr + 2'd1;
      end else begin
         nxt = (ctr == CTR_MIN) ? ctr : ctr - 2'd1;
      end
      return nxt;
   endfunction

endpackage

`default_nettype wire

// File: src/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
   input  logic                             clk,
   input  logic                             rst_n_i,
   input  logic [fetch_pkg::XLEN-1:0]       base_pc_i,  // Group base address
   input  fetch_pkg::resolve_t              resolve_i,
   output logic [fetch_pkg::FETCH_W-1:0]    taken_o     // Counter MSB per slot
);

   import fetch_pkg::*;
   import bpred_pkg::*;

   // ========================================
   // Counter table
   // ========================================
   ctr_t bht_q [BHT_ENTRIES];

   logic [FETCH_W-1:0][BHT_IDX_W-1:0] rd_idx;   // One read port per slot
   logic [BHT_IDX_W-1:0]              upd_idx;
   logic                              upd_en;

   // ========================================
   // Lookup
   // ========================================

   // Slots of a group are consecutive words, so indices are consecutive
   // modulo the table size unless the group straddles a wrap
   always_comb begin
      for (int i = 0; i < FETCH_W; i++) begin
         rd_idx[i]  = bht_index(base_pc_i + XLEN'(4 * i));
         taken_o[i] = bht_q[rd_idx[i]][1];   // MSB set means taken
      end
   end

   // ========================================
   // Training
   // ========================================

   // Only conditional branches train, JAL and JALR never touch the table
   assign upd_en  = resolve_i.valid && resolve_i.is_branch;
   assign upd_idx = bht_index(resolve_i.pc);

   // Written value shows up on lookups from the next cycle on
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int e = 0; e < BHT_ENTRIES; e++) begin
            bht_q[e] <= CTR_WNT;              // All weakly not taken
         end
      end else if (upd_en) begin
         bht_q[upd_idx] <= ctr_next(bht_q[upd_idx], resolve_i.taken);
      end
   end

endmodule

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   // ========================================
   // Fetch geometry
   // ========================================
   localparam int XLEN        = 32;                        // Data and address width
   localparam int FETCH_W     = 4;                         // Slots per fetch group
   localparam int SLOT_IDX_W  = $clog2(FETCH_W);           // Slot number width
   localparam int GROUP_BYTES = 4 * FETCH_W;               // Fall-through stride
   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;   // First fetch address

   // Downstream instruction buffer, one entry per group
   localparam int BUF_CREDITS = 4;
   localparam int CREDIT_W    = $clog2(BUF_CREDITS + 1);  // Holds 0..BUF_CREDITS

   // RV32 major opcodes seen by the early decoder
   localparam logic [6:0] OPCODE_BRANCH = 7'b110_0011;
   localparam logic [6:0] OPCODE_JAL    = 7'b110_1111;
   localparam logic [6:0] OPCODE_JALR   = 7'b110_0111;

   typedef enum logic [1:0] {
      OPC_BRANCH,
      OPC_JAL,
      OPC_JALR,     // Fetched but falls through
      OPC_OTHER
   } opcode_e;

   typedef enum logic [1:0] {
      PC_HOLD,      // Back-pressure, refetch same address
      PC_ADVANCE,   // Group sent, move to next PC
      PC_REDIRECT   // Mispredict from back end
   } pc_cmd_e;

   typedef struct packed {
      opcode_e         kind;
      logic [XLEN-1:0] imm;    // Zero for non-control words
   } predecode_t;

   typedef struct packed {
      logic [XLEN-1:0] instr;
      logic [XLEN-1:0] pc;
      logic            taken;  // Predicted taken
   } fetch_slot_t;

   typedef struct packed {
      logic [FETCH_W-1:0]        valid;  // Contiguous from slot 0
      fetch_slot_t [FETCH_W-1:0] slot;
   } fetch_group_t;

   // Single resolve port from the back end
   typedef struct packed {
      logic            valid;
      logic            is_branch;   // Conditional branch, trains the BHT
      logic            taken;       // Resolved outcome
      logic            mispredict;  // Forces a redirect
      logic [XLEN-1:0] pc;
      logic [XLEN-1:0] target;      // Correct next PC
   } resolve_t;

endpackage

`default_nettype wire

// File: src/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
   input  logic                                            clk,
   input  logic                                            rst_n_i,

   // Instruction memory, read combinationally
   output logic [fetch_pkg::XLEN-1:0]                      fetch_addr_o,
   input  logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::XLEN-1:0] instr_i,

   // Back end resolve port
   input  fetch_pkg::resolve_t                             resolve_i,

   // Instruction buffer, credit based
   output fetch_pkg::fetch_group_t                         group_o,
   output logic                                            group_valid_o,
   input  logic                                            credit_return_i
);

   import fetch_pkg::*;

   predecode_t [FETCH_W-1:0]       pdec;          // Per-slot early decode
   logic [FETCH_W-1:0]             pred_taken;    // Raw BHT bits
   logic [XLEN-1:0]                pc;
   logic [FETCH_W-1:0][XLEN-1:0]   slot_pc;
   logic [FETCH_W-1:0]             slot_mask;
   logic [FETCH_W-1:0]             slot_taken;

   pc_cmd_e                        pc_cmd;
   logic                           flush;         // Mispredict this cycle
   logic                           send;
   logic [CREDIT_W-1:0]            credit_q;      // Free buffer entries

   // ========================================
   // Early decode, one per slot
   // ========================================
   for (genvar g = 0; g < FETCH_W; g++) begin : g_dec
      imm_decoder u_imm_dec (
         .instr_i (instr_i[g]),
         .pdec_o  (pdec[g])
      );
   end

   // ========================================
   // Send decision and PC command
   // ========================================
   assign flush = resolve_i.valid && resolve_i.mispredict;

   // Redirect beats a send, a send needs a free entry
   always_comb begin
      if (!rst_n_i) begin
         pc_cmd = PC_HOLD;                 // Nothing leaves while in reset
      end else if (flush) begin
         pc_cmd = PC_REDIRECT;
      end else if (credit_q != '0) begin
         pc_cmd = PC_ADVANCE;
      end else begin
         pc_cmd = PC_HOLD;
      end
   end

   assign send          = (pc_cmd == PC_ADVANCE);
   assign group_valid_o = send;

   // ========================================
   // Credit counter
   // ========================================

   // Send and return together cancel out
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         credit_q <= CREDIT_W'(BUF_CREDITS);   // Buffer starts empty
      end else begin
         unique case ({send, credit_return_i})
            2'b10: credit_q <= credit_q - 1'b1;
            2'b01: begin
               // A return while full would be a buffer bug, count stays capped
               if (credit_q != CREDIT_W'(BUF_CREDITS)) begin
                  credit_q <= credit_q + 1'b1;
               end
            end
            default: credit_q <= credit_q;
         endcase
      end
   end

   // ========================================
   // Predictor and PC generator
   // ========================================
   branch_predictor u_bpred (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .base_pc_i (pc),
      .resolve_i (resolve_i),
      .taken_o   (pred_taken)
   );

   pc_gen u_pc_gen (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .cmd_i         (pc_cmd),
      .redirect_pc_i (resolve_i.target),
      .pdec_i        (pdec),
      .pred_taken_i  (pred_taken),
      .pc_o          (pc),
      .slot_pc_o     (slot_pc),
      .slot_mask_o   (slot_mask),
      .slot_taken_o  (slot_taken)
   );

   assign fetch_addr_o = pc;   // Base of the group in flight

   // ========================================
   // Output group
   // ========================================

   // Qualified by group_valid_o, slots past the first taken one are masked
   always_comb begin
      group_o.valid = slot_mask;
      for (int i = 0; i < FETCH_W; i++) begin
         group_o.slot[i].instr = instr_i[i];
         group_o.slot[i].pc    = slot_pc[i];
         group_o.slot[i].taken = slot_taken[i];
      end
   end

endmodule

`default_nettype wire

// File: src/imm_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module imm_decoder (
   input  logic [fetch_pkg::XLEN-1:0] instr_i,
   output fetch_pkg::predecode_t      pdec_o
);

   import fetch_pkg::*;

   logic [6:0]      opcode;
   logic [XLEN-1:0] imm_b;   // Branch offset
   logic [XLEN-1:0] imm_j;   // JAL offset

   assign opcode = instr_i[6:0];

   // B-type: imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
   assign imm_b = {{19{instr_i[31]}},
                   instr_i[31],
                   instr_i[7],
                   instr_i[30:25],
                   instr_i[11:8],
                   1'b0};

   // J-type: imm[20|10:1|11|19:12] in 31:12
   assign imm_j = {{11{instr_i[31]}},
                   instr_i[31],
                   instr_i[19:12],
                   instr_i[20],
                   instr_i[30:21],
                   1'b0};

   // Classify by major opcode only, funct3 is not checked here
   always_comb begin
      unique case (opcode)
         OPCODE_BRANCH: begin
            pdec_o.kind = OPC_BRANCH;
            pdec_o.imm  = imm_b;
         end
         OPCODE_JAL: begin
            pdec_o.kind = OPC_JAL;
            pdec_o.imm  = imm_j;
         end
         OPCODE_JALR: begin
            pdec_o.kind = OPC_JALR;    // Register target, unknown at fetch
            pdec_o.imm  = '0;
         end
         default: begin
            pdec_o.kind = OPC_OTHER;
            pdec_o.imm  = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
   input  logic                                          clk,
   input  logic                                          rst_n_i,
   input  fetch_pkg::pc_cmd_e                            cmd_i,
   input  logic [fetch_pkg::XLEN-1:0]                    redirect_pc_i,
   input  fetch_pkg::predecode_t [fetch_pkg::FETCH_W-1:0] pdec_i,
   input  logic [fetch_pkg::FETCH_W-1:0]                 pred_taken_i,
   output logic [fetch_pkg::XLEN-1:0]                    pc_o,
   output logic [fetch_pkg::FETCH_W-1:0][fetch_pkg::XLEN-1:0] slot_pc_o,
   output logic [fetch_pkg::FETCH_W-1:0]                 slot_mask_o,
   output logic [fetch_pkg::FETCH_W-1:0]                 slot_taken_o
);

   import fetch_pkg::*;

   logic [XLEN-1:0]                pc_q;        // Group base address
   logic [XLEN-1:0]                next_pc;
   logic [FETCH_W-1:0][XLEN-1:0]   slot_tgt;    // PC-relative targets
   logic                           any_taken;
   logic [SLOT_IDX_W-1:0]          first_idx;   // Lowest taken slot

   assign pc_o = pc_q;

   // ========================================
   // Per-slot PCs, targets and taken flags
   // ========================================
   always_comb begin
      for (int i = 0; i < FETCH_W; i++) begin
         slot_pc_o[i]    = pc_q + XLEN'(4 * i);
         slot_tgt[i]     = slot_pc_o[i] + pdec_i[i].imm;
         // JAL always redirects, branch follows the BHT, JALR falls through
         slot_taken_o[i] = (pdec_i[i].kind == OPC_JAL) ||
                           ((pdec_i[i].kind == OPC_BRANCH) && pred_taken_i[i]);
      end
   end

   // ========================================
   // First taken slot, mask and next PC
   // ========================================
   always_comb begin
      any_taken = 1'b0;
      first_idx = '0;
      // Scan downward so the lowest taken slot wins
      for (int i = FETCH_W - 1; i >= 0; i--) begin
         if (slot_taken_o[i]) begin
            any_taken = 1'b1;
            first_idx = SLOT_IDX_W'(i);
         end
      end
      for (int i = 0; i < FETCH_W; i++) begin
         slot_mask_o[i] = !any_taken || (i <= int'(first_idx));  // Keep up to taken slot
      end
      next_pc = any_taken ? slot_tgt[first_idx] : pc_q + XLEN'(GROUP_BYTES);
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         pc_q <= RESET_PC;
      end else begin
         unique case (cmd_i)
            PC_ADVANCE:  pc_q <= next_pc;
            PC_REDIRECT: pc_q <= redirect_pc_i;     // Back end wins over prediction
            default:     pc_q <= pc_q;              // Refetch under back-pressure
         endcase
      end
   end

endmodule

`default_nettype wire

// File: superfetch.f
src/fetch_pkg.sv
src/bpred_pkg.sv
src/imm_decoder.sv
src/branch_predictor.sv
src/pc_gen.sv
src/fetch_unit.sv
dv/fetch_asserts.sv
dv/fetch_tb.sv
